// File: hdl/bbox_cfg_pkg.sv
`default_nettype none

package bbox_cfg_pkg;

    //////////////////////////////
    // default sizes
    //////////////////////////////

    parameter int NUM_PIXELS_DEF = 16;  // pixels per frame
    parameter int NUM_FRAMES_DEF = 3;   // frames per set, 2 or more
    parameter int NUM_SETS_DEF   = 5;

    //////////////////////////////
    // widths
    //////////////////////////////

    parameter int PIX_W   = 8;
    parameter int SET_W   = 3;

    // four 16 bit lanes per beat, up to 64 frames
    parameter int SUM_W   = 24;

    // sum times a 16 bit scale
    parameter int SCORE_W = 40;

    typedef logic [PIX_W-1:0]   pix_idx_t;
    typedef logic [SET_W-1:0]   set_idx_t;
    typedef logic [SUM_W-1:0]   prob_sum_t;
    typedef logic [SCORE_W-1:0] score_t;

endpackage

`default_nettype wire

// File: hdl/bbox_word_pkg.sv
`default_nettype none

package bbox_word_pkg;

    parameter int LANE_W = 16;

    typedef logic [LANE_W-1:0] lane_t;

    //////////////////////////////
    // 64 bit stream beat
    //////////////////////////////

    // later frames use all four lanes for probabilities,
    // the first frame of a set gives lane 0 to the scale
    typedef union packed {
        lane_t [3:0] prob;          // prob[0] in bits 15:0
        struct packed {
            lane_t [2:0] prob;      // bits 63:16
            lane_t       scale;     // bits 15:0
        } first;
    } stream_word_t;

endpackage

`default_nettype wire

// File: hdl/bbox_input_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_input_ctrl #(
    parameter int NUM_PIXELS = bbox_cfg_pkg::NUM_PIXELS_DEF,
    parameter int NUM_FRAMES = bbox_cfg_pkg::NUM_FRAMES_DEF,
    parameter int NUM_SETS   = bbox_cfg_pkg::NUM_SETS_DEF
) (
    input  logic                        clk,
    input  logic                        reset,
    input  bbox_word_pkg::stream_word_t stream_data,
    input  logic                        stream_valid,
    output logic                        stream_ready,
    input  logic                        read_done,
    input  logic                        best_strobe,
    input  bbox_cfg_pkg::set_idx_t      best_set,
    input  bbox_cfg_pkg::pix_idx_t      best_pixel,
    output logic                        beat_strobe,
    output bbox_word_pkg::stream_word_t beat_word,
    output bbox_cfg_pkg::set_idx_t      beat_set,
    output bbox_cfg_pkg::pix_idx_t      beat_pixel,
    output logic                        first_frame,
    output logic [63:0]                 box_word,
    output bbox_cfg_pkg::set_idx_t      box_set,
    output bbox_cfg_pkg::pix_idx_t      box_pixel,
    output logic                        box_valid
);

    localparam int FRAME_W = $clog2(NUM_FRAMES);

    localparam logic [2:0] ST_START     = 3'd0;  // one idle cycle after reset
    localparam logic [2:0] ST_PROB      = 3'd1;
    localparam logic [2:0] ST_WAIT_BEST = 3'd2;
    localparam logic [2:0] ST_BOX       = 3'd3;
    localparam logic [2:0] ST_HOLD      = 3'd4;

    logic [2:0]             state;
    bbox_cfg_pkg::pix_idx_t pix_cnt;
    logic [FRAME_W-1:0]     frame_cnt;
    bbox_cfg_pkg::set_idx_t set_cnt;
    logic                   take;
    logic                   last_pixel;
    logic                   last_frame;
    logic                   last_set;
    logic                   hit;

    assign take       = stream_valid && stream_ready;
    assign last_pixel = (pix_cnt == bbox_cfg_pkg::pix_idx_t'(NUM_PIXELS - 1));
    assign last_frame = (frame_cnt == FRAME_W'(NUM_FRAMES - 1));
    assign last_set   = (set_cnt == bbox_cfg_pkg::set_idx_t'(NUM_SETS - 1));
    assign hit        = (set_cnt == box_set) && (pix_cnt == box_pixel);

    //////////////////////////////
    // phase control and counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_START;
            stream_ready <= 1'b0;
            beat_strobe  <= 1'b0;
            box_valid    <= 1'b0;
            pix_cnt      <= '0;
            frame_cnt    <= '0;
            set_cnt      <= '0;
        end else begin
            beat_strobe <= 1'b0;
            case (state)
                ST_START: begin
                    stream_ready <= 1'b1;
                    state        <= ST_PROB;
                end
                ST_PROB: begin
                    if (take) begin
                        beat_strobe <= 1'b1;
                        pix_cnt     <= pix_cnt + 1'b1;
                        if (last_pixel) begin
                            pix_cnt   <= '0;
                            frame_cnt <= frame_cnt + 1'b1;
                            if (last_frame) begin
                                frame_cnt <= '0;
                                set_cnt   <= set_cnt + 1'b1;
                                if (last_set) begin
                                    set_cnt      <= '0;
                                    stream_ready <= 1'b0;  // hold off until scan is done
                                    state        <= ST_WAIT_BEST;
                                end
                            end
                        end
                    end
                end
                ST_WAIT_BEST: begin
                    if (best_strobe) begin
                        stream_ready <= 1'b1;
                        state        <= ST_BOX;
                    end
                end
                ST_BOX: begin
                    if (take) begin
                        pix_cnt <= pix_cnt + 1'b1;
                        if (last_pixel) begin
                            pix_cnt <= '0;
                            set_cnt <= set_cnt + 1'b1;
                            if (last_set) begin
                                set_cnt      <= '0;
                                stream_ready <= 1'b0;
                                box_valid    <= 1'b1;
                                state        <= ST_HOLD;
                            end
                        end
                    end
                end
                ST_HOLD: begin
                    if (read_done) begin
                        box_valid    <= 1'b0;
                        stream_ready <= 1'b1;  // next run starts right away
                        state        <= ST_PROB;
                    end
                end
                default: state <= ST_START;
            endcase
        end
    end

    //////////////////////////////
    // beat and result payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_PROB && take) begin
            beat_word   <= stream_data;
            beat_set    <= set_cnt;
            beat_pixel  <= pix_cnt;
            first_frame <= (frame_cnt == '0);
        end
        if (state == ST_WAIT_BEST && best_strobe) begin
            box_set   <= best_set;    // winning position, also the capture target
            box_pixel <= best_pixel;
        end
        if (state == ST_BOX && take && hit) begin
            box_word <= stream_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/prob_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module prob_accumulator #(
    parameter int NUM_PIXELS = bbox_cfg_pkg::NUM_PIXELS_DEF,
    parameter int NUM_FRAMES = bbox_cfg_pkg::NUM_FRAMES_DEF,
    parameter int NUM_SETS   = bbox_cfg_pkg::NUM_SETS_DEF
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        beat_strobe,
    input  bbox_word_pkg::stream_word_t beat_word,
    input  bbox_cfg_pkg::set_idx_t      beat_set,
    input  bbox_cfg_pkg::pix_idx_t      beat_pixel,
    input  logic                        first_frame,
    input  bbox_cfg_pkg::set_idx_t      rd_set,
    input  bbox_cfg_pkg::pix_idx_t      rd_pixel,
    output logic                        set_done_strobe,
    output bbox_cfg_pkg::set_idx_t      done_set,
    output bbox_cfg_pkg::prob_sum_t     rd_sum,
    output bbox_word_pkg::lane_t        rd_scale
);

    localparam int DEPTH   = NUM_SETS * NUM_PIXELS;
    localparam int ADDR_W  = $clog2(DEPTH);
    localparam int FRAME_W = $clog2(NUM_FRAMES);

    bbox_cfg_pkg::prob_sum_t sum_mem   [DEPTH];
    bbox_word_pkg::lane_t    scale_mem [DEPTH];

    logic [ADDR_W-1:0]       wr_addr;
    logic [ADDR_W-1:0]       rd_addr;
    bbox_cfg_pkg::prob_sum_t lane_total;
    bbox_cfg_pkg::prob_sum_t new_sum;
    logic [FRAME_W-1:0]      frame_cnt;   // frames seen in the current set
    logic                    last_pixel;

    // set major layout
    assign wr_addr    = ADDR_W'(int'(beat_set) * NUM_PIXELS + int'(beat_pixel));
    assign rd_addr    = ADDR_W'(int'(rd_set) * NUM_PIXELS + int'(rd_pixel));
    assign last_pixel = (beat_pixel == bbox_cfg_pkg::pix_idx_t'(NUM_PIXELS - 1));

    //////////////////////////////
    // lane decode and sum
    //////////////////////////////

    always_comb begin
        lane_total = '0;
        if (first_frame) begin
            for (int i = 0; i < 3; i++) begin
                lane_total = lane_total + bbox_cfg_pkg::prob_sum_t'(beat_word.first.prob[i]);
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                lane_total = lane_total + bbox_cfg_pkg::prob_sum_t'(beat_word.prob[i]);
            end
        end
        // first frame starts a fresh sum
        new_sum = first_frame ? lane_total : sum_mem[wr_addr] + lane_total;
    end

    always_ff @(posedge clk) begin
        if (beat_strobe) begin
            sum_mem[wr_addr] <= new_sum;
            if (first_frame) begin
                scale_mem[wr_addr] <= beat_word.first.scale;
            end
        end
        rd_sum   <= sum_mem[rd_addr];    // scanner read port, 1 cycle
        rd_scale <= scale_mem[rd_addr];
        if (beat_strobe) begin
            done_set <= beat_set;
        end
    end

    //////////////////////////////
    // set completion
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_cnt       <= '0;
            set_done_strobe <= 1'b0;
        end else begin
            set_done_strobe <= 1'b0;
            if (beat_strobe && last_pixel) begin
                if (first_frame) begin
                    frame_cnt <= FRAME_W'(1);
                end else if (frame_cnt == FRAME_W'(NUM_FRAMES - 1)) begin
                    frame_cnt       <= '0;
                    set_done_strobe <= 1'b1;  // last sum written on this same edge
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/argmax_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module argmax_scanner #(
    parameter int NUM_PIXELS = bbox_cfg_pkg::NUM_PIXELS_DEF,
    parameter int NUM_SETS   = bbox_cfg_pkg::NUM_SETS_DEF
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    set_done_strobe,
    input  bbox_cfg_pkg::set_idx_t  done_set,
    output bbox_cfg_pkg::set_idx_t  rd_set,
    output bbox_cfg_pkg::pix_idx_t  rd_pixel,
    input  bbox_cfg_pkg::prob_sum_t rd_sum,
    input  bbox_word_pkg::lane_t    rd_scale,
    output logic                    best_strobe,
    output bbox_cfg_pkg::set_idx_t  best_set,
    output bbox_cfg_pkg::pix_idx_t  best_pixel
);

    logic                   scanning;
    logic                   scan_last;
    logic                   pipe_valid;   // rd_sum and rd_scale belong to pipe_set/pipe_pixel
    bbox_cfg_pkg::set_idx_t pipe_set;
    bbox_cfg_pkg::pix_idx_t pipe_pixel;
    bbox_cfg_pkg::score_t   score;
    bbox_cfg_pkg::score_t   best_score;
    logic                   take_best;

    assign scan_last = (rd_pixel == bbox_cfg_pkg::pix_idx_t'(NUM_PIXELS - 1));
    assign score     = bbox_cfg_pkg::score_t'(rd_sum) * bbox_cfg_pkg::score_t'(rd_scale);

    // strict compare keeps the earliest position on ties;
    // set 0 pixel 0 restarts the search for a new run
    assign take_best = pipe_valid
                     && ((pipe_set == '0 && pipe_pixel == '0) || score > best_score);

    //////////////////////////////
    // address walk
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            scanning    <= 1'b0;
            rd_set      <= '0;
            rd_pixel    <= '0;
            pipe_valid  <= 1'b0;
            best_strobe <= 1'b0;
        end else begin
            pipe_valid  <= scanning;
            best_strobe <= pipe_valid
                        && pipe_pixel == bbox_cfg_pkg::pix_idx_t'(NUM_PIXELS - 1)
                        && pipe_set == bbox_cfg_pkg::set_idx_t'(NUM_SETS - 1);
            if (set_done_strobe) begin
                scanning <= 1'b1;
                rd_set   <= done_set;
                rd_pixel <= '0;
            end else if (scanning) begin
                if (scan_last) begin
                    scanning <= 1'b0;
                end else begin
                    rd_pixel <= rd_pixel + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // score compare
    //////////////////////////////

    always_ff @(posedge clk) begin
        pipe_set   <= rd_set;      // align with registered read data
        pipe_pixel <= rd_pixel;
        if (take_best) begin
            best_score <= score;
            best_set   <= pipe_set;
            best_pixel <= pipe_pixel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bounding_box.sv
`timescale 1ns/1ps
`default_nettype none

module bounding_box #(
    parameter int NUM_PIXELS = bbox_cfg_pkg::NUM_PIXELS_DEF,
    parameter int NUM_FRAMES = bbox_cfg_pkg::NUM_FRAMES_DEF,
    parameter int NUM_SETS   = bbox_cfg_pkg::NUM_SETS_DEF
) (
    input  logic                        clk,
    input  logic                        reset,
    input  bbox_word_pkg::stream_word_t stream_data,
    input  logic                        stream_valid,
    output logic                        stream_ready,
    input  logic                        read_done,
    output logic [63:0]                 box_word,
    output bbox_cfg_pkg::set_idx_t      box_set,
    output bbox_cfg_pkg::pix_idx_t      box_pixel,
    output logic                        box_valid
);

    // input control to accumulator
    logic                        beat_strobe;
    bbox_word_pkg::stream_word_t beat_word;
    bbox_cfg_pkg::set_idx_t      beat_set;
    bbox_cfg_pkg::pix_idx_t      beat_pixel;
    logic                        first_frame;

    // accumulator to scanner
    logic                        set_done_strobe;
    bbox_cfg_pkg::set_idx_t      done_set;
    bbox_cfg_pkg::set_idx_t      rd_set;
    bbox_cfg_pkg::pix_idx_t      rd_pixel;
    bbox_cfg_pkg::prob_sum_t     rd_sum;
    bbox_word_pkg::lane_t        rd_scale;

    // scanner back to input control
    logic                        best_strobe;
    bbox_cfg_pkg::set_idx_t      best_set;
    bbox_cfg_pkg::pix_idx_t      best_pixel;

    bbox_input_ctrl #(
        .NUM_PIXELS (NUM_PIXELS),
        .NUM_FRAMES (NUM_FRAMES),
        .NUM_SETS   (NUM_SETS)
    ) bbox_input_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .stream_ready (stream_ready),
        .read_done    (read_done),
        .best_strobe  (best_strobe),
        .best_set     (best_set),
        .best_pixel   (best_pixel),
        .beat_strobe  (beat_strobe),
        .beat_word    (beat_word),
        .beat_set     (beat_set),
        .beat_pixel   (beat_pixel),
        .first_frame  (first_frame),
        .box_word     (box_word),
        .box_set      (box_set),
        .box_pixel    (box_pixel),
        .box_valid    (box_valid)
    );

    prob_accumulator #(
        .NUM_PIXELS (NUM_PIXELS),
        .NUM_FRAMES (NUM_FRAMES),
        .NUM_SETS   (NUM_SETS)
    ) prob_accumulator_i (
        .clk             (clk),
        .reset           (reset),
        .beat_strobe     (beat_strobe),
        .beat_word       (beat_word),
        .beat_set        (beat_set),
        .beat_pixel      (beat_pixel),
        .first_frame     (first_frame),
        .rd_set          (rd_set),
        .rd_pixel        (rd_pixel),
        .set_done_strobe (set_done_strobe),
        .done_set        (done_set),
        .rd_sum          (rd_sum),
        .rd_scale        (rd_scale)
    );

    argmax_scanner #(
        .NUM_PIXELS (NUM_PIXELS),
        .NUM_SETS   (NUM_SETS)
    ) argmax_scanner_i (
        .clk             (clk),
        .reset           (reset),
        .set_done_strobe (set_done_strobe),
        .done_set        (done_set),
        .rd_set          (rd_set),
        .rd_pixel        (rd_pixel),
        .rd_sum          (rd_sum),
        .rd_scale        (rd_scale),
        .best_strobe     (best_strobe),
        .best_set        (best_set),
        .best_pixel      (best_pixel)
    );

endmodule

`default_nettype wire

// File: tb/tb_bounding_box.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bounding_box;

    localparam int NUM_PIXELS = bbox_cfg_pkg::NUM_PIXELS_DEF;
    localparam int NUM_FRAMES = bbox_cfg_pkg::NUM_FRAMES_DEF;
    localparam int NUM_SETS   = bbox_cfg_pkg::NUM_SETS_DEF;

    localparam int BEATS_PER_RUN   = NUM_SETS * NUM_PIXELS * (NUM_FRAMES + 1);
    localparam int NUM_RUNS        = 5;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (BEATS_PER_RUN * 4 + 200);

    // stimulus kinds
    localparam int RUN_RANDOM    = 0;
    localparam int RUN_EQUAL     = 1;
    localparam int RUN_ONE_SCALE = 2;
    localparam int RUN_SATURATED = 3;

    logic                        clk = 1'b0;
    logic                        reset;
    bbox_word_pkg::stream_word_t stream_data;
    logic                        stream_valid;
    logic                        stream_ready;
    logic                        read_done;
    logic [63:0]                 box_word;
    bbox_cfg_pkg::set_idx_t      box_set;
    bbox_cfg_pkg::pix_idx_t      box_pixel;
    logic                        box_valid;

    logic [63:0] prob_words [NUM_SETS][NUM_FRAMES][NUM_PIXELS];
    logic [63:0] box_words  [NUM_SETS][NUM_PIXELS];

    // expected results with one entry per run in flight
    bbox_cfg_pkg::set_idx_t exp_set_q   [$];
    bbox_cfg_pkg::pix_idx_t exp_pixel_q [$];
    logic [63:0]            exp_word_q  [$];
    int                     checked_count = 0;

    int run_kinds [NUM_RUNS] = '{RUN_RANDOM, RUN_EQUAL, RUN_ONE_SCALE, RUN_SATURATED, RUN_RANDOM};

    always #20 clk = ~clk;

    bounding_box #(
        .NUM_PIXELS (NUM_PIXELS),
        .NUM_FRAMES (NUM_FRAMES),
        .NUM_SETS   (NUM_SETS)
    ) bounding_box_i (
        .clk          (clk),
        .reset        (reset),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .stream_ready (stream_ready),
        .read_done    (read_done),
        .box_word     (box_word),
        .box_set      (box_set),
        .box_pixel    (box_pixel),
        .box_valid    (box_valid)
    );

    //////////////////////////////
    // failure and compare tasks
    //////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_set(input string name, input bbox_cfg_pkg::set_idx_t got,
                               input bbox_cfg_pkg::set_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s expected %0d got %0d",
                                $time, name, exp, got));
        end
    endtask

    task automatic compare_pixel(input string name, input bbox_cfg_pkg::pix_idx_t got,
                                 input bbox_cfg_pkg::pix_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s expected %0d got %0d",
                                $time, name, exp, got));
        end
    endtask

    task automatic compare_word(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s expected %h got %h",
                                $time, name, exp, got));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s expected %b got %b",
                                $time, name, exp, got));
        end
    endtask

    //////////////////////////////
    // stimulus and reference
    //////////////////////////////

    // lane 0 of frame 0 is the scale and all other lanes are probabilities
    task automatic fill_run(input int kind);
        int          hot_set;
        int          hot_pixel;
        logic [15:0] lane [4];
        hot_set   = int'($urandom % NUM_SETS);
        hot_pixel = int'($urandom % NUM_PIXELS);
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int f = 0; f < NUM_FRAMES; f++) begin
                for (int p = 0; p < NUM_PIXELS; p++) begin
                    for (int l = 0; l < 4; l++) begin
                        case (kind)
                            RUN_RANDOM:    lane[l] = 16'($urandom);
                            RUN_EQUAL:     lane[l] = 16'h0123;
                            RUN_ONE_SCALE: lane[l] = 16'($urandom) | 16'h0001;  // no zero sums
                            default:       lane[l] = 16'hffff;
                        endcase
                    end
                    if (f == 0 && kind == RUN_ONE_SCALE) begin
                        lane[0] = (s == hot_set && p == hot_pixel) ?
                                  (16'($urandom) | 16'h0001) : 16'h0000;
                    end else if (f == 0 && kind == RUN_SATURATED) begin
                        lane[0] = 16'($urandom);  // scales still differ
                    end
                    prob_words[s][f][p] = {lane[3], lane[2], lane[1], lane[0]};
                end
            end
            for (int p = 0; p < NUM_PIXELS; p++) begin
                box_words[s][p] = {$urandom, $urandom};
            end
        end
    endtask

    // highest sum times scale wins and the earliest position keeps a tie
    function automatic void find_winner(output bbox_cfg_pkg::set_idx_t win_set,
                                        output bbox_cfg_pkg::pix_idx_t win_pixel);
        logic [63:0] sum;
        logic [63:0] score;
        logic [63:0] best;
        logic [63:0] w;
        best      = '0;
        win_set   = '0;
        win_pixel = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                sum = '0;
                for (int f = 0; f < NUM_FRAMES; f++) begin
                    w = prob_words[s][f][p];
                    for (int l = (f == 0) ? 1 : 0; l < 4; l++) begin
                        sum = sum + 64'(w[16*l +: 16]);
                    end
                end
                score = sum * 64'(prob_words[s][0][p][15:0]);
                if (score > best) begin
                    best      = score;
                    win_set   = bbox_cfg_pkg::set_idx_t'(s);
                    win_pixel = bbox_cfg_pkg::pix_idx_t'(p);
                end
            end
        end
    endfunction

    // called right after a rising edge and holds the beat until it is taken
    task automatic send_beat(input logic [63:0] word);
        int   gap;
        logic taken;
        gap = ($urandom % 4 == 0) ? 1 + int'($urandom % 2) : 0;
        if (gap > 0) begin
            stream_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        stream_data  <= word;
        stream_valid <= 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = (stream_ready === 1'b1);  // ready is stable mid cycle
            @(posedge clk);
        end
    endtask

    task automatic send_run();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int f = 0; f < NUM_FRAMES; f++) begin
                for (int p = 0; p < NUM_PIXELS; p++) begin
                    send_beat(prob_words[s][f][p]);
                end
            end
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                send_beat(box_words[s][p]);
            end
        end
    endtask

    initial begin : drive_stimulus
        bbox_cfg_pkg::set_idx_t win_set;
        bbox_cfg_pkg::pix_idx_t win_pixel;
        void'($urandom(32'hcdac2c1a));
        reset        <= 1'b1;
        stream_data  <= '0;
        stream_valid <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            compare_bit("stream_ready", stream_ready, 1'b0);  // last pass is the cycle after
            compare_bit("box_valid", box_valid, 1'b0);
        end
        @(posedge clk);
        for (int r = 0; r < NUM_RUNS; r++) begin
            fill_run(run_kinds[r]);
            find_winner(win_set, win_pixel);
            exp_set_q.push_back(win_set);
            exp_pixel_q.push_back(win_pixel);
            exp_word_q.push_back(box_words[win_set][win_pixel]);
            send_run();
        end
        stream_valid <= 1'b0;
        wait (checked_count == NUM_RUNS);
        @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

    //////////////////////////////
    // result check and watchdog
    //////////////////////////////

    initial begin : check_results
        bbox_cfg_pkg::set_idx_t exp_set;
        bbox_cfg_pkg::pix_idx_t exp_pixel;
        logic [63:0]            exp_word;
        int                     hold;
        read_done <= 1'b0;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (box_valid === 1'b1) begin
                if (exp_set_q.size() == 0) begin
                    abort_run("box_valid rose with no run outstanding");
                end else begin
                    exp_set   = exp_set_q.pop_front();
                    exp_pixel = exp_pixel_q.pop_front();
                    exp_word  = exp_word_q.pop_front();
                    compare_bit("stream_ready", stream_ready, 1'b0);
                    hold = 1 + int'($urandom % 5);
                    for (int i = 0; i < hold; i++) begin
                        compare_bit("box_valid", box_valid, 1'b1);
                        compare_set("box_set", box_set, exp_set);
                        compare_pixel("box_pixel", box_pixel, exp_pixel);
                        compare_word("box_word", box_word, exp_word);
                        @(negedge clk);
                    end
                    @(posedge clk);
                    read_done <= 1'b1;
                    @(posedge clk);
                    read_done <= 1'b0;
                    @(negedge clk);
                    compare_bit("box_valid", box_valid, 1'b0);  // released so the next run may start
                    compare_bit("stream_ready", stream_ready, 1'b1);
                    checked_count++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES + 10) @(posedge clk);
        abort_run($sformatf("timeout: runs not finished after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

// File: list.f
hdl/bbox_cfg_pkg.sv
hdl/bbox_word_pkg.sv
hdl/bbox_input_ctrl.sv
hdl/prob_accumulator.sv
hdl/argmax_scanner.sv
hdl/bounding_box.sv
tb/tb_bounding_box.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_bounding_box
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
